/* verilog.f */
spi_pkg.sv
spi_clock_gen.sv
spi_shifter.sv
spi_sequencer.sv
mfrc522_spi_master.sv
tb_mfrc522_model.sv
tb_mfrc522_spi_master_properties.sv
tb_mfrc522_spi_master.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f \
    --top-module tb_mfrc522_spi_master -o tb_sim
status=0
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit "$status"

/* tb_mfrc522_spi_master.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mfrc522_spi_master;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                          clk;
    logic                          rst;
    logic                          start;
    spi_pkg::spi_cmd_t             cmd;
    wire                           miso;
    spi_pkg::spi_pins_t            pins;
    logic [spi_pkg::BYTE_BITS-1:0] rd_data;
    logic                          rd_valid;
    logic                          busy;
    logic                          done;

    int          errors;
    int          timeouts;
    logic [15:0] lfsr;
    logic [7:0]  mirror [64];
    logic [7:0]  rd_seen [$];

    always #4 clk = ~clk;

    mfrc522_spi_master mfrc522_spi_master_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .cmd      (cmd),
        .miso     (miso),
        .pins     (pins),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .busy     (busy),
        .done     (done)
    );

    tb_mfrc522_model model_i (
        .clk  (clk),
        .pins (pins),
        .miso (miso)
    );

    bind mfrc522_spi_master tb_mfrc522_spi_master_properties props_i (
        .clk      (clk),
        .rst      (rst),
        .pins     (pins),
        .busy     (busy),
        .done     (done),
        .rd_valid (rd_valid)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 16'hB400;
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    endtask

    task automatic finish_run();
        int asserts;
        asserts = mfrc522_spi_master_i.props_i.fail_total;
        $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, asserts);
        if (errors == 0 && timeouts == 0 && asserts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // One-cycle start strobe with the command
    task automatic issue_cmd(input spi_pkg::spi_dir_t dir, input logic [5:0] addr,
                             input logic [7:0] data, input logic [7:0] count);
        rd_seen.delete();
        @(posedge clk);
        #1;
        start     = 1'b1;
        cmd.dir   = dir;
        cmd.addr  = addr;
        cmd.data  = data;
        cmd.count = count;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // Collects read bytes until done
    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            if (rd_valid) begin
                rd_seen.push_back(rd_data);
            end
            cycles++;
        end while (!done && cycles < TIMEOUT_CYCLES);
        if (!done) begin
            timeouts++;
            $display("Timeout in %s: done did not arrive within %0d cycles",
                     name, TIMEOUT_CYCLES);
        end
    endtask

    // Bytes seen by the model, register contents and read data
    task automatic check_frame(input string name, input spi_pkg::spi_dir_t dir,
                               input logic [5:0] addr, input logic [7:0] value,
                               input int beats);
        logic       rw;
        int         head;
        logic [7:0] addr_byte;
        rw        = (dir == spi_pkg::DIR_READ);
        head      = rw ? 2 : 1;
        addr_byte = {rw, addr, 1'b0};
        if (model_i.frame_bytes.size() != head + beats) begin
            report_mismatch({name, " frame length"}, head + beats,
                            model_i.frame_bytes.size());
        end else begin
            if (model_i.frame_bytes[0] !== addr_byte) begin
                report_mismatch({name, " address byte"}, int'(addr_byte),
                                int'(model_i.frame_bytes[0]));
            end
            if (rw && model_i.frame_bytes[1] !== 8'h00) begin
                report_mismatch({name, " dummy byte"}, 0, int'(model_i.frame_bytes[1]));
            end
            for (int i = head; i < head + beats; i++) begin
                if (!rw && model_i.frame_bytes[i] !== value) begin
                    report_mismatch({name, " data byte"}, int'(value),
                                    int'(model_i.frame_bytes[i]));
                end
            end
        end
        if (rw) begin
            if (rd_seen.size() != beats) begin
                report_mismatch({name, " rd_valid count"}, beats, rd_seen.size());
            end
            foreach (rd_seen[i]) begin
                if (rd_seen[i] !== value) begin
                    report_mismatch({name, " rd_data"}, int'(value), int'(rd_seen[i]));
                end
            end
        end else if (model_i.regs[addr] !== value) begin
            report_mismatch({name, " register"}, int'(value), int'(model_i.regs[addr]));
        end
    endtask

    task automatic transfer(input string name, input spi_pkg::spi_dir_t dir,
                            input logic [5:0] addr, input logic [7:0] data,
                            input logic [7:0] count);
        int         beats;
        logic [7:0] value;
        // Zero count still moves one byte
        beats = (count == 8'd0) ? 1 : int'(count);
        value = (dir == spi_pkg::DIR_WRITE) ? data : mirror[addr];
        issue_cmd(dir, addr, data, count);
        wait_done(name);
        check_frame(name, dir, addr, value, beats);
        if (dir == spi_pkg::DIR_WRITE) begin
            mirror[addr] = data;
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_reset_state();
        if (pins.cs_n !== 1'b1) begin
            report_mismatch("reset_state cs_n", 1, int'(pins.cs_n));
        end
        if (pins.sck !== 1'b0) begin
            report_mismatch("reset_state sck", 0, int'(pins.sck));
        end
        if (pins.mosi !== 1'b0) begin
            report_mismatch("reset_state mosi", 0, int'(pins.mosi));
        end
        if (busy !== 1'b0 || done !== 1'b0 || rd_valid !== 1'b0) begin
            report_mismatch("reset_state status", 0, int'({busy, done, rd_valid}));
        end
    endtask

    task automatic test_single_write();
        int          falls0;
        logic [15:0] r;
        falls0 = model_i.cs_falls;
        take_bits(8, r);
        transfer("single_write", spi_pkg::DIR_WRITE, 6'h2a, r[7:0], 8'd1);
        if (model_i.cs_falls - falls0 != 1) begin
            report_mismatch("single_write cs falls", 1, model_i.cs_falls - falls0);
        end
        if (pins.cs_n !== 1'b1) begin
            report_mismatch("single_write cs_n after done", 1, int'(pins.cs_n));
        end
    endtask

    task automatic test_burst_write();
        logic [15:0] r;
        take_bits(8, r);
        transfer("burst_write_4", spi_pkg::DIR_WRITE, 6'h11, r[7:0], 8'd4);
        take_bits(8, r);
        transfer("burst_write_0", spi_pkg::DIR_WRITE, 6'h12, r[7:0], 8'd0);
    endtask

    task automatic test_read_back();
        transfer("read_single", spi_pkg::DIR_READ, 6'h2a, 8'h00, 8'd1);
        transfer("read_burst", spi_pkg::DIR_READ, 6'h11, 8'h00, 8'd3);
    endtask

    task automatic test_start_while_busy();
        int          falls0;
        int          bytes0;
        int          cycles;
        logic [15:0] r;
        falls0 = model_i.cs_falls;
        bytes0 = model_i.all_bytes.size();
        take_bits(8, r);
        issue_cmd(spi_pkg::DIR_WRITE, 6'h05, r[7:0], 8'd1);
        cycles = 0;
        while (!busy && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy) begin
            timeouts++;
            $display("Timeout in start_while_busy: busy never rose");
        end
        // Second strobe lands mid-transaction
        issue_cmd(spi_pkg::DIR_WRITE, 6'h06, ~r[7:0], 8'd2);
        wait_done("start_while_busy");
        check_frame("start_while_busy", spi_pkg::DIR_WRITE, 6'h05, r[7:0], 1);
        mirror[5] = r[7:0];
        if (model_i.all_bytes.size() - bytes0 != 2) begin
            report_mismatch("start_while_busy byte total", 2,
                            model_i.all_bytes.size() - bytes0);
        end
        if (model_i.cs_falls - falls0 != 1) begin
            report_mismatch("start_while_busy cs falls", 1, model_i.cs_falls - falls0);
        end
        if (model_i.regs[6] !== mirror[6]) begin
            report_mismatch("start_while_busy reg 6", int'(mirror[6]), int'(model_i.regs[6]));
        end
        // No late second transaction
        repeat (40) begin
            @(negedge clk);
            if (busy) begin
                report_mismatch("start_while_busy late busy", 0, 1);
            end
        end
    endtask

    task automatic test_random_traffic();
        logic [15:0]        r;
        logic [7:0]         data;
        logic [7:0]         count;
        logic [5:0]         addr;
        spi_pkg::spi_dir_t  dir;
        // Fill every register first
        for (int a = 0; a < 64; a++) begin
            take_bits(8, r);
            data = r[7:0];
            take_bits(2, r);
            count = {6'b0, r[1:0]};
            transfer("random_fill", spi_pkg::DIR_WRITE, a[5:0], data, count);
        end
        // Mixed reads and writes, back to back
        for (int i = 0; i < 48; i++) begin
            take_bits(1, r);
            dir = spi_pkg::spi_dir_t'(r[0]);
            take_bits(6, r);
            addr = r[5:0];
            take_bits(8, r);
            data = r[7:0];
            take_bits(2, r);
            count = {6'b0, r[1:0]};
            transfer("random_mix", dir, addr, data, count);
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        cmd      = '0;
        errors   = 0;
        timeouts = 0;
        lfsr     = 16'd1079;
        for (int a = 0; a < 64; a++) begin
            mirror[a] = 8'h00;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        test_reset_state();
        test_single_write();
        test_burst_write();
        test_read_back();
        test_start_while_busy();
        test_random_traffic();
        finish_run();
    end

endmodule

`default_nettype wire

/* tb_mfrc522_spi_master_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mfrc522_spi_master_properties (
    input wire                     clk,
    input wire                     rst,
    input wire spi_pkg::spi_pins_t pins,
    input wire                     busy,
    input wire                     done,
    input wire                     rd_valid
);

    int sck_fails;
    int done_fails;
    int mosi_fails;
    int valid_fails;
    int fail_total;

    initial begin
        sck_fails   = 0;
        done_fails  = 0;
        mosi_fails  = 0;
        valid_fails = 0;
    end

    // Read from the testbench at the end of the run
    assign fail_total = sck_fails + done_fails + mosi_fails + valid_fails;

    // ----------------------------------------------------------------------
    // Pin rules
    // ----------------------------------------------------------------------

    // SCK parked low with the chip deselected
    sck_idle_low: assert property (@(posedge clk) disable iff (rst) pins.cs_n |-> !pins.sck)
        else begin
            sck_fails++;
            $error("SCK high while cs_n is high");
        end

    // Mode 0, data settled before the rise
    mosi_stable_at_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(pins.sck) |-> $stable(pins.mosi))
        else begin
            mosi_fails++;
            $error("MOSI changed together with an SCK rise");
        end

    // ----------------------------------------------------------------------
    // Status rules
    // ----------------------------------------------------------------------

    // One-cycle pulse, exactly where busy drops
    done_single_pulse: assert property (@(posedge clk) disable iff (rst)
        (done |=> !done) and (done == $fell(busy)))
        else begin
            done_fails++;
            $error("done is not a single pulse at the fall of busy");
        end

    valid_in_busy: assert property (@(posedge clk) disable iff (rst) rd_valid |-> busy)
        else begin
            valid_fails++;
            $error("rd_valid outside a transaction");
        end

endmodule

`default_nettype wire

/* tb_mfrc522_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mfrc522_model (
    input  wire                     clk,
    input  wire spi_pkg::spi_pins_t pins,
    output logic                    miso
);

    // Register file as the chip would hold it
    logic [7:0] regs [64];

    // Byte logs read by the testbench
    logic [7:0] frame_bytes [$];
    logic [7:0] all_bytes [$];
    int         cs_falls;

    logic       sck_q;
    logic       cs_n_q;
    logic [7:0] in_sr;
    logic [7:0] out_sr;
    int         bit_cnt;
    int         byte_idx;
    logic       rd_mode;
    logic [5:0] addr;

    initial begin
        miso     = 1'b0;
        sck_q    = 1'b0;
        cs_n_q   = 1'b1;
        in_sr    = 8'h00;
        out_sr   = 8'h00;
        bit_cnt  = 0;
        byte_idx = 0;
        rd_mode  = 1'b0;
        addr     = 6'h00;
        cs_falls = 0;
        for (int i = 0; i < 64; i++) begin
            regs[i] = 8'h00;
        end
    end

    // ----------------------------------------------------------------------
    // Slave side, pins looked at mid-cycle
    // ----------------------------------------------------------------------

    always @(negedge clk) begin : slave_fsm
        logic [7:0] byte_v;
        if (cs_n_q && !pins.cs_n) begin
            // New frame starts
            cs_falls++;
            frame_bytes.delete();
            bit_cnt  = 0;
            byte_idx = 0;
        end else if (!pins.cs_n && pins.sck && !sck_q) begin
            // SCK rise, take MOSI
            byte_v = {in_sr[6:0], pins.mosi};
            in_sr  = byte_v;
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                frame_bytes.push_back(byte_v);
                all_bytes.push_back(byte_v);
                if (byte_idx == 0) begin
                    // rw, address, one unused bit
                    rd_mode = byte_v[7];
                    addr    = byte_v[6:1];
                end else if (!rd_mode) begin
                    // Last write byte wins
                    regs[addr] = byte_v;
                end
                // Dummy or data byte over, queue the register again
                if (rd_mode && byte_idx >= 1) begin
                    out_sr = regs[addr];
                end
                byte_idx++;
            end
        end else if (!pins.cs_n && !pins.sck && sck_q) begin
            // SCK fall, next read bit MSB first
            miso   = out_sr[7];
            out_sr = {out_sr[6:0], 1'b0};
        end
        sck_q  = pins.sck;
        cs_n_q = pins.cs_n;
    end

endmodule

`default_nettype wire

/* mfrc522_spi_master.sv */
`timescale 1ns/100ps
`default_nettype none

module mfrc522_spi_master (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire  spi_pkg::spi_cmd_t         cmd,
    input  wire                             miso,
    output spi_pkg::spi_pins_t              pins,
    output logic [spi_pkg::BYTE_BITS-1:0]   rd_data,
    output logic                            rd_valid,
    output logic                            busy,
    output logic                            done
);

    // ----------------------------------------------------------------------
    // Internal nets
    // ----------------------------------------------------------------------

    logic                          run;
    logic                          load;
    logic [spi_pkg::BYTE_BITS-1:0] tx_byte;
    logic                          cs_n;
    logic                          sck;
    logic                          mosi;
    logic                          sample_edge;
    logic                          shift_edge;
    logic                          byte_end;

    assign pins = spi_pkg::spi_pins_t'{cs_n: cs_n, sck: sck, mosi: mosi};

    // FSM, chip select and status
    spi_sequencer spi_sequencer_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .cmd      (cmd),
        .byte_end (byte_end),
        .run      (run),
        .load     (load),
        .tx_byte  (tx_byte),
        .cs_n     (cs_n),
        .rd_valid (rd_valid),
        .busy     (busy),
        .done     (done)
    );

    // SCK divider and bit timing
    spi_clock_gen spi_clock_gen_i (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .sck         (sck),
        .sample_edge (sample_edge),
        .shift_edge  (shift_edge),
        .byte_end    (byte_end)
    );

    // MOSI out, MISO in
    spi_shifter spi_shifter_i (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .tx_byte     (tx_byte),
        .shift_edge  (shift_edge),
        .sample_edge (sample_edge),
        .byte_end    (byte_end),
        .miso        (miso),
        .mosi        (mosi),
        .rx_byte     (rd_data)
    );

endmodule

`default_nettype wire

/* spi_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_sequencer (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire  spi_pkg::spi_cmd_t         cmd,
    input  wire                             byte_end,
    output logic                            run,
    output logic                            load,
    output logic [spi_pkg::BYTE_BITS-1:0]   tx_byte,
    output logic                            cs_n,
    output logic                            rd_valid,
    output logic                            busy,
    output logic                            done
);

    spi_pkg::seq_state_t              state;
    spi_pkg::spi_cmd_t                cmd_q;
    logic [spi_pkg::COUNT_BITS-1:0]   bytes_left;
    logic [spi_pkg::TIMER_BITS-1:0]   timer;
    logic [spi_pkg::BYTE_BITS-1:0]    addr_byte;

    // Address byte is rw, six address bits, then a zero
    assign addr_byte = {cmd_q.dir == spi_pkg::DIR_READ, cmd_q.addr, 1'b0};

    // ----------------------------------------------------------------------
    // Transaction FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= spi_pkg::ST_IDLE;
            bytes_left <= '0;
            timer      <= '0;
            done       <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            done     <= 1'b0;
            rd_valid <= byte_end && (state == spi_pkg::ST_RECV_DATA);
            case (state)
                spi_pkg::ST_IDLE: begin
                    // A start while busy never reaches this branch
                    if (start) begin
                        timer <= '0;
                        if (cmd.count == '0) begin
                            bytes_left <= spi_pkg::COUNT_BITS'(1);
                        end else begin
                            bytes_left <= cmd.count;
                        end
                        state <= spi_pkg::ST_CS_SETUP;
                    end
                end
                spi_pkg::ST_CS_SETUP: begin
                    if (timer == spi_pkg::SETUP_LAST) begin
                        timer <= '0;
                        state <= spi_pkg::ST_SEND_ADDR;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                spi_pkg::ST_SEND_ADDR: begin
                    if (byte_end) begin
                        if (cmd_q.dir == spi_pkg::DIR_READ) begin
                            state <= spi_pkg::ST_SEND_DUMMY;
                        end else begin
                            state <= spi_pkg::ST_SEND_DATA;
                        end
                    end
                end
                spi_pkg::ST_SEND_DUMMY: begin
                    if (byte_end) begin
                        state <= spi_pkg::ST_RECV_DATA;
                    end
                end
                spi_pkg::ST_SEND_DATA, spi_pkg::ST_RECV_DATA: begin
                    // Data phases share the countdown
                    if (byte_end) begin
                        bytes_left <= bytes_left - 1'b1;
                        if (bytes_left == spi_pkg::COUNT_BITS'(1)) begin
                            state <= spi_pkg::ST_CS_HOLD;
                        end
                    end
                end
                spi_pkg::ST_CS_HOLD: begin
                    if (timer == spi_pkg::HOLD_LAST) begin
                        timer <= '0;
                        done  <= 1'b1;
                        state <= spi_pkg::ST_IDLE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= spi_pkg::ST_IDLE;
            endcase
        end
    end

    // Command copy, data byte reused for every write beat
    always_ff @(posedge clk) begin
        if ((state == spi_pkg::ST_IDLE) && start) begin
            cmd_q <= cmd;
        end
    end

    // ----------------------------------------------------------------------
    // Byte choice and pin level outputs
    // ----------------------------------------------------------------------

    always_comb begin
        case (state)
            spi_pkg::ST_CS_SETUP, spi_pkg::ST_SEND_ADDR: tx_byte = addr_byte;
            spi_pkg::ST_SEND_DATA:                        tx_byte = cmd_q.data;
            default:                                      tx_byte = spi_pkg::DUMMY_BYTE;
        endcase
    end

    // Address goes in once, first setup cycle
    assign load = (state == spi_pkg::ST_CS_SETUP) && (timer == '0);

    assign run = (state == spi_pkg::ST_SEND_ADDR) || (state == spi_pkg::ST_SEND_DUMMY) ||
                 (state == spi_pkg::ST_SEND_DATA) || (state == spi_pkg::ST_RECV_DATA);

    assign cs_n = (state == spi_pkg::ST_IDLE);
    assign busy = (state != spi_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* spi_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_shifter (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             load,
    input  wire  [spi_pkg::BYTE_BITS-1:0]   tx_byte,
    input  wire                             shift_edge,
    input  wire                             sample_edge,
    input  wire                             byte_end,
    input  wire                             miso,
    output logic                            mosi,
    output logic [spi_pkg::BYTE_BITS-1:0]   rx_byte
);

    logic [spi_pkg::BYTE_BITS-1:0] tx_sr;
    logic [spi_pkg::BYTE_BITS-1:0] rx_sr;
    logic                          reload_pending;

    // ----------------------------------------------------------------------
    // Transmit side
    // ----------------------------------------------------------------------

    // Set by a finished byte, the next fall brings in the new byte
    always_ff @(posedge clk) begin
        if (rst) begin
            reload_pending <= 1'b0;
        end else if (load) begin
            reload_pending <= 1'b0;
        end else if (byte_end) begin
            reload_pending <= 1'b1;
        end else if (shift_edge) begin
            reload_pending <= 1'b0;
        end
    end

    // MSB first, cleared so MOSI idles low out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_sr <= '0;
        end else if (load) begin
            tx_sr <= tx_byte;
        end else if (shift_edge) begin
            if (reload_pending) begin
                tx_sr <= tx_byte;
            end else begin
                tx_sr <= {tx_sr[spi_pkg::BYTE_BITS-2:0], 1'b0};
            end
        end
    end

    assign mosi = tx_sr[spi_pkg::BYTE_BITS-1];

    // ----------------------------------------------------------------------
    // Receive side
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (sample_edge) begin
            rx_sr <= {rx_sr[spi_pkg::BYTE_BITS-2:0], miso};
        end
        // Complete byte includes the bit sampled on this edge
        if (byte_end) begin
            rx_byte <= {rx_sr[spi_pkg::BYTE_BITS-2:0], miso};
        end
    end

endmodule

`default_nettype wire

/* spi_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_clock_gen (
    input  wire  clk,
    input  wire  rst,
    input  wire  run,
    output logic sck,
    output logic sample_edge,
    output logic shift_edge,
    output logic byte_end
);

    logic [spi_pkg::DIV_BITS-1:0]     div_cnt;
    logic [spi_pkg::BIT_CNT_BITS-1:0] bit_cnt;
    logic                             tick;

    // ----------------------------------------------------------------------
    // Edge strobes
    // ----------------------------------------------------------------------

    // Last clock of a half period, SCK flips on this edge
    assign tick = run && (div_cnt == spi_pkg::DIV_LAST);

    // Mode 0: rise samples, fall shifts
    assign sample_edge = tick && !sck;
    assign shift_edge  = tick && sck;

    // Eighth rise of the byte
    assign byte_end = sample_edge && (bit_cnt == spi_pkg::BIT_LAST);

    // ----------------------------------------------------------------------
    // Divider and bit counter
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            // SCK parks low between bursts
            div_cnt <= '0;
            bit_cnt <= '0;
            sck     <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            sck     <= ~sck;
            // Count bits on the rising half only
            if (!sck) begin
                if (bit_cnt == spi_pkg::BIT_LAST) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* spi_pkg.sv */
`default_nettype none

package spi_pkg;

    // ----------------------------------------------------------------------
    // Frame and divider constants
    // ----------------------------------------------------------------------

    // One SPI byte, the MFRC522 address field and the burst length
    localparam int BYTE_BITS  = 8;
    localparam int ADDR_BITS  = 6;
    localparam int COUNT_BITS = 8;

    // SCK half period in system clocks
    localparam int SCK_HALF_CYCLES = 4;

    // Chip select guard times around the SCK burst
    localparam int CS_SETUP_CYCLES = 2;
    localparam int CS_HOLD_CYCLES  = 2;

    // Byte clocked out while the chip prepares read data
    localparam logic [BYTE_BITS-1:0] DUMMY_BYTE = 8'h00;

    // Counter widths and terminal values
    localparam int DIV_BITS     = (SCK_HALF_CYCLES > 1) ? $clog2(SCK_HALF_CYCLES) : 1;
    localparam int BIT_CNT_BITS = $clog2(BYTE_BITS);
    localparam int TIMER_BITS   = $clog2(CS_SETUP_CYCLES + CS_HOLD_CYCLES + 1);

    localparam logic [DIV_BITS-1:0]     DIV_LAST   = DIV_BITS'(SCK_HALF_CYCLES - 1);
    localparam logic [BIT_CNT_BITS-1:0] BIT_LAST   = BIT_CNT_BITS'(BYTE_BITS - 1);
    localparam logic [TIMER_BITS-1:0]   SETUP_LAST = TIMER_BITS'(CS_SETUP_CYCLES - 1);
    localparam logic [TIMER_BITS-1:0]   HOLD_LAST  = TIMER_BITS'(CS_HOLD_CYCLES - 1);

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    // Becomes the rw bit, MSB of the address byte
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } spi_dir_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CS_SETUP,
        ST_SEND_ADDR,
        ST_SEND_DUMMY,
        ST_SEND_DATA,
        ST_RECV_DATA,
        ST_CS_HOLD
    } seq_state_t;

    // Count of 0 still moves one byte
    typedef struct packed {
        spi_dir_t               dir;
        logic [ADDR_BITS-1:0]   addr;
        logic [BYTE_BITS-1:0]   data;
        logic [COUNT_BITS-1:0]  count;
    } spi_cmd_t;

    // Master side of the chip interface
    typedef struct packed {
        logic cs_n;
        logic sck;
        logic mosi;
    } spi_pins_t;

endpackage

`default_nettype wire
